//--- common/rv32_types_pkg.sv
// Declares the RV32 data word and memory opcode types shared by the RTL and the bench

package rv32_types_pkg;

    // One architectural data word
    typedef logic [31:0] rv32_word;

    // Memory operation on the data port
    // Loads and stores follow the RV32I mnemonics
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        // Sign-extended loads
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        // Zero-extended loads
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        // Stores
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_t;

endpackage

//--- common/rv32_mem_pkg.sv
// Declares the main memory organization and port handshake states for the memory and both ports

package rv32_mem_pkg;

    // Depth of the memory in 32-bit words
    localparam int unsigned NUM_WORDS = 1024;

    // Word address width
    localparam int unsigned ADDR_WIDTH = $clog2(NUM_WORDS);

    // Byte lanes per word with one bank each
    localparam int unsigned NUM_LANES = 4;

    // Wishbone slave handshake
    // PORT_RESP lasts one cycle and carries ack or err
    typedef enum logic {
        PORT_IDLE = 1'b0,
        PORT_RESP = 1'b1
    } port_state_t;

endpackage

//--- memory/byte_bank.sv
// Byte-wide true dual-port RAM bank instantiated once per byte lane of the main memory

module byte_bank #(
    parameter int unsigned ADDR_WIDTH = rv32_mem_pkg::ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Port a reads only
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  logic                  read_a,
    // Port b reads and writes
    input  logic [ADDR_WIDTH-1:0] addr_b,
    input  logic                  read_b,
    input  logic                  we_b,
    input  logic [7:0]            data_in_b,
    output logic [7:0]            data_a,
    output logic [7:0]            data_b
);

    localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_b) begin
            mem[addr_b] <= data_in_b;
        end
    end

    // Reads sample the array before the write at the same edge lands
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_a <= '0;
            data_b <= '0;
        end else begin
            if (read_a) begin
                data_a <= mem[addr_a];
            end
            if (read_b) begin
                data_b <= mem[addr_b];
            end
        end
    end

endmodule

//--- memory/rv32_main_memory.sv
// Word memory built from four byte banks that serves fetches on port a and data on port b

module rv32_main_memory (
    input  logic                                clk,
    input  logic                                rst_n,
    // Fetch side
    input  logic                                fetch_en,
    input  logic [rv32_mem_pkg::ADDR_WIDTH-1:0] fetch_addr,
    output rv32_types_pkg::rv32_word            fetch_rdata,
    // Data side with write data already steered onto its lanes
    input  logic                                mem_en,
    input  logic [rv32_mem_pkg::ADDR_WIDTH-1:0] mem_addr,
    input  logic [3:0]                          mem_we,
    input  rv32_types_pkg::rv32_word            mem_wdata,
    output rv32_types_pkg::rv32_word            mem_rdata
);

    import rv32_mem_pkg::*;

    logic [NUM_LANES-1:0] lane_we;

    // A lane writes only inside an issued data request
    assign lane_we = mem_en ? mem_we : '0;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        byte_bank #(
            .ADDR_WIDTH (ADDR_WIDTH)
        ) u_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .addr_a    (fetch_addr),
            .read_a    (fetch_en),
            .addr_b    (mem_addr),
            .read_b    (mem_en),
            .we_b      (lane_we[i]),
            .data_in_b (mem_wdata[8*i +: 8]),
            .data_a    (fetch_rdata[8*i +: 8]),
            .data_b    (mem_rdata[8*i +: 8])
        );
    end

endmodule

//--- logic/instr_port.sv
// Wishbone classic slave that checks each fetch address and reads one word from memory

module instr_port (
    input  logic                                clk,
    input  logic                                rst_n,
    // Wishbone slave
    input  logic                                i_cyc,
    input  logic                                i_stb,
    input  logic [31:0]                         i_adr,
    output rv32_types_pkg::rv32_word            i_dat_r,
    output logic                                i_ack,
    output logic                                i_err,
    // Memory request
    output logic                                fetch_en,
    output logic [rv32_mem_pkg::ADDR_WIDTH-1:0] fetch_addr,
    input  rv32_types_pkg::rv32_word            fetch_rdata
);

    import rv32_mem_pkg::*;

    port_state_t state;
    logic        accept;
    logic        aligned;
    logic        in_range;
    logic        legal;

    assign accept   = (state == PORT_IDLE) && i_cyc && i_stb;
    assign aligned  = (i_adr[1:0] == 2'b00);
    assign in_range = (i_adr[31:2] < 30'(NUM_WORDS));
    assign legal    = aligned && in_range;

    // Read issued only in the accepting cycle of a legal fetch
    assign fetch_en   = accept && legal;
    assign fetch_addr = i_adr[ADDR_WIDTH+1:2];

    // Bank output register holds the word during the ack cycle
    assign i_dat_r = fetch_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PORT_IDLE;
            i_ack <= 1'b0;
            i_err <= 1'b0;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (accept) begin
                        state <= PORT_RESP;
                        i_ack <= legal;
                        i_err <= !legal;
                    end
                end
                PORT_RESP: begin
                    // The held stb is ignored here
                    state <= PORT_IDLE;
                    i_ack <= 1'b0;
                    i_err <= 1'b0;
                end
                default: begin
                    state <= PORT_IDLE;
                    i_ack <= 1'b0;
                    i_err <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- logic/data_port.sv
// Wishbone classic slave that steers byte lanes for RV32 stores and extends load data

module data_port (
    input  logic                                clk,
    input  logic                                rst_n,
    // Wishbone slave where op replaces sel
    input  logic                                d_cyc,
    input  logic                                d_stb,
    input  logic                                d_we,
    input  logic [31:0]                         d_adr,
    input  rv32_types_pkg::rv32_word            d_dat_w,
    input  rv32_types_pkg::mem_op_t             d_op,
    output rv32_types_pkg::rv32_word            d_dat_r,
    output logic                                d_ack,
    output logic                                d_err,
    // Memory request
    output logic                                mem_en,
    output logic [rv32_mem_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [3:0]                          mem_we,
    output rv32_types_pkg::rv32_word            mem_wdata,
    input  rv32_types_pkg::rv32_word            mem_rdata
);

    import rv32_types_pkg::*;
    import rv32_mem_pkg::*;

    port_state_t state;
    logic        accept;
    logic        is_load;
    logic        is_store;
    logic        misaligned;
    logic        in_range;
    logic        dir_ok;
    logic        legal;
    logic [3:0]  lane_mask;

    // Load context kept for the response cycle
    mem_op_t     op_q;
    logic [1:0]  off_q;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign accept = (state == PORT_IDLE) && d_cyc && d_stb;

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        lane_mask  = 4'b0000;
        mem_wdata  = d_dat_w;
        case (d_op)
            MEM_LB, MEM_LBU: is_load = 1'b1;
            MEM_LH, MEM_LHU: begin
                is_load    = 1'b1;
                misaligned = d_adr[0];
            end
            MEM_LW: begin
                is_load    = 1'b1;
                misaligned = (d_adr[1:0] != 2'b00);
            end
            MEM_SB: begin
                is_store  = 1'b1;
                lane_mask = 4'b0001 << d_adr[1:0];
                mem_wdata = {4{d_dat_w[7:0]}};
            end
            MEM_SH: begin
                is_store   = 1'b1;
                misaligned = d_adr[0];
                lane_mask  = d_adr[1] ? 4'b1100 : 4'b0011;
                mem_wdata  = {2{d_dat_w[15:0]}};
            end
            MEM_SW: begin
                is_store   = 1'b1;
                misaligned = (d_adr[1:0] != 2'b00);
                lane_mask  = 4'b1111;
            end
            default: ;
        endcase
    end

    // MEM_NONE matches neither direction and ends in err
    assign dir_ok   = (is_load && !d_we) || (is_store && d_we);
    assign in_range = (d_adr[31:2] < 30'(NUM_WORDS));
    assign legal    = dir_ok && !misaligned && in_range;

    assign mem_en   = accept && legal;
    assign mem_addr = d_adr[ADDR_WIDTH+1:2];
    assign mem_we   = mem_en ? lane_mask : 4'b0000;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= d_op;
            off_q <= d_adr[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PORT_IDLE;
            d_ack <= 1'b0;
            d_err <= 1'b0;
        end else if (state == PORT_IDLE) begin
            if (accept) begin
                state <= PORT_RESP;
                d_ack <= legal;
                d_err <= !legal;
            end
        end else begin
            state <= PORT_IDLE;
            d_ack <= 1'b0;
            d_err <= 1'b0;
        end
    end

    // Aligned halves let bit 1 pick the half
    assign lane_byte = mem_rdata[{off_q, 3'b000} +: 8];
    assign lane_half = off_q[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        d_dat_r = '0;
        if (d_ack) begin
            case (op_q)
                MEM_LB:  d_dat_r = {{24{lane_byte[7]}}, lane_byte};
                MEM_LBU: d_dat_r = {24'b0, lane_byte};
                MEM_LH:  d_dat_r = {{16{lane_half[15]}}, lane_half};
                MEM_LHU: d_dat_r = {16'b0, lane_half};
                MEM_LW:  d_dat_r = mem_rdata;
                default: d_dat_r = '0;
            endcase
        end
    end

endmodule

//--- logic/rv32_mem_top.sv
// Top level of the dual-port main memory that joins the fetch and data slaves to the banks

module rv32_mem_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Instruction port
    input  logic                     i_cyc,
    input  logic                     i_stb,
    input  logic [31:0]              i_adr,
    output rv32_types_pkg::rv32_word i_dat_r,
    output logic                     i_ack,
    output logic                     i_err,
    // Data port
    input  logic                     d_cyc,
    input  logic                     d_stb,
    input  logic                     d_we,
    input  logic [31:0]              d_adr,
    input  rv32_types_pkg::rv32_word d_dat_w,
    input  rv32_types_pkg::mem_op_t  d_op,
    output rv32_types_pkg::rv32_word d_dat_r,
    output logic                     d_ack,
    output logic                     d_err
);

    import rv32_types_pkg::*;
    import rv32_mem_pkg::*;

    logic                  fetch_en;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    rv32_word              fetch_rdata;
    logic                  mem_en;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [3:0]            mem_we;
    rv32_word              mem_wdata;
    rv32_word              mem_rdata;

    instr_port u_instr_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cyc       (i_cyc),
        .i_stb       (i_stb),
        .i_adr       (i_adr),
        .i_dat_r     (i_dat_r),
        .i_ack       (i_ack),
        .i_err       (i_err),
        .fetch_en    (fetch_en),
        .fetch_addr  (fetch_addr),
        .fetch_rdata (fetch_rdata)
    );

    data_port u_data_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .d_cyc     (d_cyc),
        .d_stb     (d_stb),
        .d_we      (d_we),
        .d_adr     (d_adr),
        .d_dat_w   (d_dat_w),
        .d_op      (d_op),
        .d_dat_r   (d_dat_r),
        .d_ack     (d_ack),
        .d_err     (d_err),
        .mem_en    (mem_en),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    rv32_main_memory u_main_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .fetch_addr  (fetch_addr),
        .fetch_rdata (fetch_rdata),
        .mem_en      (mem_en),
        .mem_addr    (mem_addr),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

endmodule

//--- bench/rv32_mem_sva.sv
// Assertion checker bound into rv32_mem_top that checks both ports against a shadow byte memory

module rv32_mem_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     i_cyc,
    input logic                     i_stb,
    input logic [31:0]              i_adr,
    input rv32_types_pkg::rv32_word i_dat_r,
    input logic                     i_ack,
    input logic                     i_err,
    input logic                     d_cyc,
    input logic                     d_stb,
    input logic                     d_we,
    input logic [31:0]              d_adr,
    input rv32_types_pkg::rv32_word d_dat_w,
    input rv32_types_pkg::mem_op_t  d_op,
    input rv32_types_pkg::rv32_word d_dat_r,
    input logic                     d_ack,
    input logic                     d_err
);

    import rv32_types_pkg::*;
    import rv32_mem_pkg::*;

    int unsigned error_count;
    logic [7:0]  shadow [NUM_WORDS*NUM_LANES];

    logic     i_acc, i_ok, i_pend, i_pend_ok;
    logic     d_acc, d_ok, d_pend, d_pend_ok, d_load;
    rv32_word i_exp, d_exp;

    initial error_count = 0;

    function rv32_word shadow_word(logic [ADDR_WIDTH-1:0] w);
        return {shadow[{w, 2'd3}], shadow[{w, 2'd2}], shadow[{w, 2'd1}], shadow[{w, 2'd0}]};
    endfunction

    // RV32 load result built from the shadow bytes at a byte address
    function automatic rv32_word load_value(mem_op_t op, logic [ADDR_WIDTH+1:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[a];
        h = {shadow[{a[ADDR_WIDTH+1:1], 1'b1}], shadow[{a[ADDR_WIDTH+1:1], 1'b0}]};
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'b0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'b0, h};
            default: return shadow_word(a[ADDR_WIDTH+1:2]);
        endcase
    endfunction

    assign i_acc = !i_pend && i_cyc && i_stb;
    assign i_ok  = (i_adr[1:0] == 2'b00) && (i_adr[31:2] < 30'(NUM_WORDS));
    assign d_acc = !d_pend && d_cyc && d_stb;

    always_comb begin
        case (d_op)
            MEM_LB, MEM_LBU: d_ok = !d_we;
            MEM_LH, MEM_LHU: d_ok = !d_we && !d_adr[0];
            MEM_LW:          d_ok = !d_we && (d_adr[1:0] == 2'b00);
            MEM_SB:          d_ok = d_we;
            MEM_SH:          d_ok = d_we && !d_adr[0];
            MEM_SW:          d_ok = d_we && (d_adr[1:0] == 2'b00);
            default:         d_ok = 1'b0;
        endcase
        d_ok = d_ok && (d_adr[31:2] < 30'(NUM_WORDS));
    end

    // Expected reads are taken before this edge's store lands in the shadow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            i_pend <= 1'b0;
            d_pend <= 1'b0;
        end else begin
            i_pend    <= i_acc;
            i_pend_ok <= i_ok;
            i_exp     <= shadow_word(i_adr[ADDR_WIDTH+1:2]);
            d_pend    <= d_acc;
            d_pend_ok <= d_ok;
            d_load    <= !d_we;
            d_exp     <= load_value(d_op, d_adr[ADDR_WIDTH+1:0]);
            if (d_acc && d_ok && d_we) begin
                case (d_op)
                    MEM_SB: shadow[d_adr[ADDR_WIDTH+1:0]] <= d_dat_w[7:0];
                    MEM_SH: begin
                        shadow[{d_adr[ADDR_WIDTH+1:1], 1'b0}] <= d_dat_w[7:0];
                        shadow[{d_adr[ADDR_WIDTH+1:1], 1'b1}] <= d_dat_w[15:8];
                    end
                    default: begin
                        for (int k = 0; k < 4; k++) begin
                            shadow[{d_adr[ADDR_WIDTH+1:2], 2'(k)}] <= d_dat_w[8*k +: 8];
                        end
                    end
                endcase
            end
        end
    end

    a_i_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !i_pend |-> !i_ack && !i_err)
        else begin
            error_count++;
            $error("Instruction port responded without an accepted request");
        end

    a_i_resp: assert property (@(posedge clk) disable iff (!rst_n)
        i_pend |-> (i_ack == i_pend_ok) && (i_err == !i_pend_ok))
        else begin
            error_count++;
            $error("[ERROR] t=%0t i_ack got %b expected %b (i_err %b)",
                   $time, $sampled(i_ack), i_pend_ok, $sampled(i_err));
        end

    a_i_data: assert property (@(posedge clk) disable iff (!rst_n)
        i_pend && i_pend_ok |-> i_dat_r == i_exp)
        else begin
            error_count++;
            $error("[ERROR] t=%0t i_dat_r got %h expected %h", $time, $sampled(i_dat_r), i_exp);
        end

    a_d_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !d_pend |-> !d_ack && !d_err)
        else begin
            error_count++;
            $error("Data port responded without an accepted request");
        end

    a_d_resp: assert property (@(posedge clk) disable iff (!rst_n)
        d_pend |-> (d_ack == d_pend_ok) && (d_err == !d_pend_ok))
        else begin
            error_count++;
            $error("[ERROR] t=%0t d_ack got %b expected %b (d_err %b)",
                   $time, $sampled(d_ack), d_pend_ok, $sampled(d_err));
        end

    a_d_data: assert property (@(posedge clk) disable iff (!rst_n)
        d_pend && d_pend_ok && d_load |-> d_dat_r == d_exp)
        else begin
            error_count++;
            $error("[ERROR] t=%0t d_dat_r got %h expected %h", $time, $sampled(d_dat_r), d_exp);
        end

endmodule

bind rv32_mem_top rv32_mem_sva u_sva (.*);

//--- bench/rv32_mem_tb.sv
// Testbench for rv32_mem_top that drives both Wishbone ports while the bound checker compares data

module rv32_mem_tb;

    import rv32_types_pkg::*;
    import rv32_mem_pkg::*;

    localparam logic [31:0] SEED = 32'hdd68_6aa2;
    localparam int N_RANDOM  = 300;
    localparam int TRANSFERS = NUM_WORDS + 64 + 2 * N_RANDOM;
    // Up to four cycles per transfer plus reset and slack
    localparam int TIMEOUT   = (TRANSFERS * 4 + 100) * 4;

    logic        clk;
    logic        rst_n;
    logic        i_cyc, i_stb;
    logic [31:0] i_adr;
    rv32_word    i_dat_r;
    logic        i_ack, i_err;
    logic        d_cyc, d_stb, d_we;
    logic [31:0] d_adr;
    rv32_word    d_dat_w;
    mem_op_t     d_op;
    rv32_word    d_dat_r;
    logic        d_ack, d_err;
    int          bench_errors;
    int          transfers;

    rv32_mem_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic rv32_word fill_word(int w);
        return (w * 32'h9e37_79b9) ^ 32'h0f0f_3c3c;
    endfunction

    // Wishbone master cycles start and end on a falling edge
    task automatic fetch_word(input logic [31:0] adr);
        int waited;
        i_adr = adr;
        i_cyc = 1'b1;
        i_stb = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(i_ack || i_err) && waited < 8);
        if (!(i_ack || i_err)) begin
            bench_errors++;
            $display("Instruction port never answered a fetch of %h at %0t", adr, $time);
        end
        i_cyc = 1'b0;
        i_stb = 1'b0;
        transfers++;
    endtask

    task automatic data_access(input logic we, input logic [31:0] adr, input rv32_word wdat,
                               input mem_op_t op);
        int waited;
        d_we    = we;
        d_adr   = adr;
        d_dat_w = wdat;
        d_op    = op;
        d_cyc   = 1'b1;
        d_stb   = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(d_ack || d_err) && waited < 8);
        if (!(d_ack || d_err)) begin
            bench_errors++;
            $display("Data port never answered %s at %h at %0t", op.name(), adr, $time);
        end
        d_cyc = 1'b0;
        d_stb = 1'b0;
        transfers++;
    endtask

    task automatic random_fetches(input int count);
        logic [31:0] r;
        logic [31:0] adr;
        r = SEED;
        for (int n = 0; n < count; n++) begin
            r   = xorshift(r);
            adr = {22'h0, r[7:0], r[9:8]};
            if (r[27:25] != 3'b000) adr[1:0] = 2'b00;
            if (r[31:28] == 4'h0) adr[31] = 1'b1;
            fetch_word(adr);
            if (r[30]) @(negedge clk);
        end
    endtask

    task automatic random_data(input int count);
        logic [31:0] r;
        logic [31:0] adr;
        mem_op_t     op;
        logic        we;
        r = xorshift(SEED ^ 32'h0000_d00d);
        for (int n = 0; n < count; n++) begin
            r   = xorshift(r);
            op  = mem_op_t'(r[19:16] % 4'd9);
            // Direction mostly follows the op with an occasional mismatch
            we  = (op >= MEM_SB) ^ (r[24:22] == 3'b000);
            adr = {22'h0, r[13:6], r[1:0]};
            if (r[27:25] != 3'b000) begin
                if (op inside {MEM_LH, MEM_LHU, MEM_SH}) adr[0] = 1'b0;
                if (op inside {MEM_LW, MEM_SW}) adr[1:0] = 2'b00;
            end
            if (r[31:28] == 4'h0) adr[12] = 1'b1;
            data_access(we, adr, xorshift(~r), op);
            if (r[5]) @(negedge clk);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        {i_cyc, i_stb, d_cyc, d_stb, d_we} = '0;
        i_adr = '0;
        d_adr = '0;
        d_dat_w = '0;
        d_op = MEM_NONE;
        bench_errors = 0;
        transfers = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        for (int w = 0; w < NUM_WORDS; w++) begin
            data_access(1'b1, w * 4, fill_word(w), MEM_SW);
        end

        data_access(1'b1, 32'h40, 32'hcafe_f00d, MEM_SW);
        data_access(1'b0, 32'h40, '0, MEM_LW);
        data_access(1'b1, 32'h41, 32'h0000_0080, MEM_SB);
        data_access(1'b1, 32'h42, 32'h1234_8001, MEM_SH);
        for (int off = 0; off < 4; off++) begin
            data_access(1'b0, 32'h40 + off, '0, MEM_LB);
            data_access(1'b0, 32'h40 + off, '0, MEM_LBU);
        end
        data_access(1'b0, 32'h40, '0, MEM_LH);
        data_access(1'b0, 32'h42, '0, MEM_LH);
        data_access(1'b0, 32'h42, '0, MEM_LHU);
        data_access(1'b0, 32'h40, '0, MEM_LW);

        // Illegal accesses that must not write
        data_access(1'b1, 32'h45, 32'hdead_0001, MEM_SH);
        data_access(1'b1, 32'h46, 32'hdead_0002, MEM_SW);
        data_access(1'b1, 32'h1000, 32'hdead_0003, MEM_SW);
        data_access(1'b0, 32'h41, '0, MEM_LW);
        data_access(1'b0, 32'h43, '0, MEM_LH);
        data_access(1'b0, 32'hffff_fffc, '0, MEM_LW);
        data_access(1'b0, 32'h44, '0, MEM_NONE);
        data_access(1'b1, 32'h44, 32'hdead_0004, MEM_LW);
        data_access(1'b0, 32'h44, '0, MEM_LW);
        // Word the out-of-range store would alias onto
        data_access(1'b0, 32'h0, '0, MEM_LW);

        fetch_word(32'h40);
        fetch_word(32'h42);
        fetch_word(32'h1000);
        fork
            data_access(1'b1, 32'h80, 32'h0bad_beef, MEM_SW);
            fetch_word(32'h80);
        join
        fetch_word(32'h80);

        fork
            random_fetches(N_RANDOM);
            random_data(N_RANDOM);
        join
        repeat (2) @(negedge clk);

        $display("Transfers %0d, assertion errors %0d, bench errors %0d",
                 transfers, uut.u_sva.error_count, bench_errors);
        if (uut.u_sva.error_count == 0 && bench_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Run timed out after %0d time units", TIMEOUT);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- rv32_mem.f
common/rv32_types_pkg.sv
common/rv32_mem_pkg.sv
memory/byte_bank.sv
memory/rv32_main_memory.sv
logic/instr_port.sv
logic/data_port.sv
logic/rv32_mem_top.sv
bench/rv32_mem_sva.sv
bench/rv32_mem_tb.sv

//--- Makefile
TOP := rv32_mem_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -f rv32_mem.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	verilator --lint-only --timing --assert -f rv32_mem.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
